/* build.f */
+incdir+include
hdl/acc_pkg.sv
hdl/psum_transpose.sv
hdl/column_reduce_tree.sv
hdl/vector_collect.sv
hdl/acc_array.sv
sim/tb_clkgen.sv
sim/acc_checker.sv
sim/tb_acc_array.sv

/* Makefile */
# Verilator build for the accumulation array testbench

VERILATOR ?= verilator
TOP       ?= tb_acc_array
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) include/acc_defs.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the exit code of the binary
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "Pass message found in $(LOG)"; \
	else \
		echo "Pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_acc_array.sv */
`timescale 1ns/10ps

`include "acc_defs.svh"

module tb_acc_array;

	import acc_pkg::*;

	localparam real CLK_PERIOD   = 8.0;
	localparam int  RESET_CYCLES = 4;
	localparam int  IDLE_CYCLES  = 4;
	localparam int  DIRECT_VECS  = 4;
	localparam int  STREAM_VECS  = 200;
	localparam int  GAP_CYCLES   = 300;
	localparam int  PHASES       = 4;

	// Every driven cycle, each drain and some margin
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + DIRECT_VECS + STREAM_VECS
		+ GAP_CYCLES + PHASES * (`ACC_LATENCY + 4) + `ACC_LATENCY + 20;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	psum_mat_t in_psum;
	logic      out_valid;
	psum_vec_t out_vector;

	int     mismatch_errs;
	int     latency_errs;
	int     protocol_errs;
	int     pending;
	int     in_count;
	int     out_count;
	integer seed;

	tb_clkgen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	acc_array UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_psum    (in_psum),
		.out_valid  (out_valid),
		.out_vector (out_vector)
	);

	acc_checker u_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_psum       (in_psum),
		.out_valid     (out_valid),
		.out_vector    (out_vector),
		.mismatch_errs (mismatch_errs),
		.latency_errs  (latency_errs),
		.protocol_errs (protocol_errs),
		.pending       (pending),
		.in_count      (in_count),
		.out_count     (out_count)
	);

	//////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////

	task automatic drive_block(input psum_mat_t blk);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		in_psum  = blk;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic make_random_block(output psum_mat_t blk);
		for (int p = 0; p < `ACC_PE_NUM; p++) begin
			for (int c = 0; c < `ACC_LANES; c++) begin
				blk[p][c] = psum_t'($random(seed));
			end
		end
	endtask

	// Wait until every block in flight has come out
	task automatic drain();
		while (pending != 0) @(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial begin : main
		psum_mat_t blk;
		int        count_errs;
		in_valid   = 1'b0;
		in_psum    = '0;
		seed       = 32'h1baf1927;
		count_errs = 0;
		wait (rst_n === 1'b1);
		repeat (IDLE_CYCLES) @(posedge clk);

		// PE p lane c holds p + 16c
		for (int p = 0; p < `ACC_PE_NUM; p++) begin
			for (int c = 0; c < `ACC_LANES; c++) begin
				blk[p][c] = psum_t'(p + 16 * c);
			end
		end
		drive_block(blk);
		drive_idle();
		drain();

		// Wrap-around blocks
		blk = '1;
		drive_block(blk);
		drive_block(blk);
		for (int p = 0; p < `ACC_PE_NUM; p++) begin
			for (int c = 0; c < `ACC_LANES; c++) begin
				blk[p][c] = 16'h8000;
			end
		end
		drive_block(blk);
		drive_idle();
		drain();

		// Back-to-back stream
		repeat (STREAM_VECS) begin
			make_random_block(blk);
			drive_block(blk);
		end
		drive_idle();
		drain();

		// Random gaps between blocks
		repeat (GAP_CYCLES) begin
			if (($random(seed) & 1) != 0) begin
				make_random_block(blk);
				drive_block(blk);
			end else begin
				drive_idle();
			end
		end
		drive_idle();
		drain();

		if (in_count != out_count || pending != 0) begin
			count_errs = 1;
			$display("Block count error: %0d blocks in, %0d out, %0d still pending",
				in_count, out_count, pending);
		end
		$display("Errors: mismatch=%0d latency=%0d other=%0d (blocks in=%0d out=%0d)",
			mismatch_errs, latency_errs, protocol_errs + count_errs, in_count, out_count);
		if (mismatch_errs + latency_errs + protocol_errs + count_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d clock cycles, outputs stalled",
			WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* sim/acc_checker.sv */
`timescale 1ns/10ps

`include "acc_defs.svh"

module acc_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  acc_pkg::psum_mat_t in_psum,
	input  logic               out_valid,
	input  acc_pkg::psum_vec_t out_vector,
	output int                 mismatch_errs,
	output int                 latency_errs,
	output int                 protocol_errs,
	output int                 pending,
	output int                 in_count,
	output int                 out_count
);

	import acc_pkg::*;

	// Expected vectors and the cycle each block was presented in
	psum_vec_t exp_q [$];
	int        stamp_q [$];

	// Rising edges seen so far
	int   cyc;
	logic seen_out;

	// Column c is lane c summed over every PE, wrapping at 16 bits
	function automatic psum_vec_t col_sums(input psum_mat_t blk);
		psum_vec_t sums;
		sums = '0;
		for (int c = 0; c < `ACC_LANES; c++) begin
			for (int p = 0; p < `ACC_PE_NUM; p++) begin
				sums[c] = sums[c] + blk[p][c];
			end
		end
		return sums;
	endfunction

	initial seen_out = 1'b0;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	//////////////////////////////////////////////////////////////
	// Sample at the falling edge, away from the driven edges
	//////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		psum_vec_t exp_v;
		int        stamp;
		if (!rst_n) begin
			if (out_valid !== 1'b0 || out_vector !== '0) begin
				protocol_errs++;
				$display("Error at %0t: outputs not cleared during reset", $time);
			end
		end else begin
			if (out_valid === 1'b1) begin
				out_count++;
				seen_out = 1'b1;
				if (exp_q.size() == 0) begin
					protocol_errs++;
					$display("Error at %0t: unexpected output with no block in flight", $time);
				end else begin
					exp_v = exp_q.pop_front();
					stamp = stamp_q.pop_front();
					if (cyc - stamp != `ACC_LATENCY) begin
						latency_errs++;
						$display("Latency error at %0t: output came %0d cycles after its input, expected %0d",
							$time, cyc - stamp, `ACC_LATENCY);
					end
					for (int c = 0; c < `ACC_LANES; c++) begin
						if (out_vector[c] !== exp_v[c]) begin
							mismatch_errs++;
							$display("Mismatch at %0t: column %0d expected %h actual %h",
								$time, c, exp_v[c], out_vector[c]);
						end
					end
				end
			end else if (out_valid !== 1'b0) begin
				protocol_errs++;
				$display("Error at %0t: out_valid is unknown", $time);
			end else if (exp_q.size() != 0 && cyc - stamp_q[0] >= `ACC_LATENCY) begin
				// Overdue block is dropped so the rest can still line up
				protocol_errs++;
				$display("Error at %0t: missing output for block sampled on cycle %0d",
					$time, stamp_q[0]);
				void'(exp_q.pop_front());
				void'(stamp_q.pop_front());
			end
			if (!seen_out && out_vector !== '0) begin
				protocol_errs++;
				$display("Error at %0t: out_vector not zero before the first result", $time);
			end
			// Block is stamped with the cycle it is presented in
			if (in_valid === 1'b1) begin
				in_count++;
				exp_q.push_back(col_sums(in_psum));
				stamp_q.push_back(cyc);
			end
		end
		pending = exp_q.size();
	end

endmodule

/* sim/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen #(
	parameter real PERIOD       = 8.0,
	parameter int  RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* hdl/acc_array.sv */
`timescale 1ns/10ps

`include "acc_defs.svh"

module acc_array (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  acc_pkg::psum_mat_t in_psum,
	output logic               out_valid,
	output acc_pkg::psum_vec_t out_vector
);

	import acc_pkg::*;

	logic                  col_valid;
	psum_mat_t             col_psum;
	logic [`ACC_LANES-1:0] sum_valid;
	psum_t                 col_sum [`ACC_LANES];

	//////////////////////////////////////////////////////////////
	// Stage 0 register and transpose
	//////////////////////////////////////////////////////////////

	psum_transpose u_transpose (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_psum   (in_psum),
		.col_valid (col_valid),
		.col_psum  (col_psum)
	);

	//////////////////////////////////////////////////////////////
	// Column reducers, one per lane
	//////////////////////////////////////////////////////////////

	for (genvar c = 0; c < `ACC_LANES; c++) begin : g_col
		column_reduce_tree #(
			.DEPTH (`ACC_TREE_DEPTH)
		) u_tree (
			.clk       (clk),
			.rst_n     (rst_n),
			.in_valid  (col_valid),
			.in_col    (col_psum[c]),
			.out_valid (sum_valid[c]),
			.out_sum   (col_sum[c])
		);
	end

	// Joins the column sums into the output vector
	vector_collect u_collect (
		.clk        (clk),
		.rst_n      (rst_n),
		.sum_valid  (sum_valid),
		.col_sum    (col_sum),
		.out_valid  (out_valid),
		.out_vector (out_vector)
	);

endmodule

/* hdl/vector_collect.sv */
`timescale 1ns/10ps

`include "acc_defs.svh"

module vector_collect (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`ACC_LANES-1:0] sum_valid,
	input  acc_pkg::psum_t     col_sum [`ACC_LANES],
	output logic               out_valid,
	output acc_pkg::psum_vec_t out_vector
);

	// All columns finish together
	logic all_valid;

	assign all_valid = &sum_valid;

	//////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= all_valid;
		end
	end

	// Vector only changes when a complete result arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_vector <= '0;
		end else if (all_valid) begin
			for (int c = 0; c < `ACC_LANES; c++) begin
				out_vector[c] <= col_sum[c];
			end
		end
	end

	// Columns drifting apart would make the AND lose a whole block
	a_cols_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		(sum_valid == '0) || (sum_valid == '1)
	) else $error("vector_collect: column valids out of step %b", sum_valid);

endmodule

/* hdl/column_reduce_tree.sv */
`timescale 1ns/10ps

`include "acc_defs.svh"

module column_reduce_tree #(
	parameter int DEPTH = `ACC_TREE_DEPTH
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  acc_pkg::psum_vec_t in_col,
	output logic              out_valid,
	output acc_pkg::psum_t    out_sum
);

	import acc_pkg::*;

	// Number of values summed by the tree
	localparam int N = 1 << DEPTH;

	//////////////////////////////////////////////////////////////
	// Tree layout
	//////////////////////////////////////////////////////////////

	// Heap numbering, node k sums nodes 2k and 2k+1
	// Nodes 1..N-1 are adders with a register each
	// Nodes N..2N-1 are the column inputs themselves
	// Since the tree is balanced every level lands on the same edge

	psum_t node_q [1:N-1];

	// Child view of the tree, leaves and registered adder outputs
	psum_t node [2:2*N-1];

	// One valid bit per adder level
	logic [DEPTH-1:0] vld_q;

	if (N > `ACC_LANES) begin : g_size_check
		$error("column_reduce_tree: 2**DEPTH exceeds the column width");
	end

	always_comb begin
		for (int k = N; k < 2 * N; k++) begin
			node[k] = in_col[k - N];
		end
		for (int k = 2; k < N; k++) begin
			node[k] = node_q[k];
		end
	end

	//////////////////////////////////////////////////////////////
	// Adder levels
	//////////////////////////////////////////////////////////////

	// Sums wrap at 16 bits so the result does not depend on order
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 1; k < N; k++) begin
				node_q[k] <= '0;
			end
		end else begin
			for (int k = 1; k < N; k++) begin
				node_q[k] <= node[2 * k] + node[2 * k + 1];
			end
		end
	end

	// Valid travels one level per cycle next to the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= (vld_q << 1) | DEPTH'(in_valid);
		end
	end

	assign out_valid = vld_q[DEPTH-1];
	assign out_sum   = node_q[1];

	//////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////

	// An X on a valid column would spread into the sum DEPTH cycles later
	a_col_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(in_col)
	) else $error("column_reduce_tree: unknown bits on a valid column");

endmodule

/* hdl/psum_transpose.sv */
`timescale 1ns/10ps

`include "acc_defs.svh"

module psum_transpose (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  acc_pkg::psum_mat_t in_psum,
	output logic              col_valid,
	output acc_pkg::psum_mat_t col_psum
);

	import acc_pkg::*;

	// Block with PE and lane order swapped
	psum_mat_t swapped;

	//////////////////////////////////////////////////////////////
	// Lane split
	//////////////////////////////////////////////////////////////

	// Column c collects lane c of every PE
	always_comb begin
		for (int c = 0; c < `ACC_LANES; c++) begin
			for (int p = 0; p < `ACC_PE_NUM; p++) begin
				swapped[c][p] = in_psum[p][c];
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Input register stage
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_valid <= 1'b0;
		end else begin
			col_valid <= in_valid;
		end
	end

	// Data only moves on a valid block, idle cycles keep the last one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_psum <= '0;
		end else if (in_valid) begin
			col_psum <= swapped;
		end
	end

endmodule

/* hdl/acc_pkg.sv */
`include "acc_defs.svh"

package acc_pkg;

	//////////////////////////////////////////////////////////////
	// Partial-sum datatypes
	//////////////////////////////////////////////////////////////

	// One 16-bit two's-complement partial sum
	typedef logic [`ACC_DATA_W-1:0] psum_t;

	// One PE row, one column or the output vector
	// Element c sits at bits 16c upward
	typedef psum_t [`ACC_LANES-1:0] psum_vec_t;

	// Full block from the PE grid, element p is PE p
	typedef psum_vec_t [`ACC_PE_NUM-1:0] psum_mat_t;

endpackage

/* include/acc_defs.svh */
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

//////////////////////////////////////////////////////////////
// Array geometry
//////////////////////////////////////////////////////////////

// Processing elements feeding the array
`define ACC_PE_NUM 16

// Lanes per PE, one reducer column each
`define ACC_LANES 16

// Width of one partial sum
`define ACC_DATA_W 16

//////////////////////////////////////////////////////////////
// Pipeline timing
//////////////////////////////////////////////////////////////

// Adder levels, log2 of ACC_PE_NUM
`define ACC_TREE_DEPTH 4

// Input register + tree levels + output register
`define ACC_LATENCY (`ACC_TREE_DEPTH + 2)

`endif
